//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_cmd_ctrl_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +incdir%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder import ecs_pkg::*; (
	input  logic        clk_50m,
	input  logic        rst,
	input  cmd_frame_t  rx_frame,
	input  logic        rx_ready,
	output logic        cmd_valid,
	output cmd_op_t     cmd_op,
	output logic [23:0] cmd_arg
);

	logic    chk_ok;   // check byte matches
	cmd_op_t op_dec;

	assign chk_ok = (rx_frame.check ==
		(rx_frame.code ^ rx_frame.sub ^ rx_frame.arg_hi ^ rx_frame.arg_lo));

	// code/sub lookup, anything unknown is op_none
	always_comb
	begin
		op_dec = op_none;
		if (rx_frame.code[7:4] == code_dio)
			op_dec = op_dio;
		else if (rx_frame.code == code_link && rx_frame.arg_hi == 8'h00)
		begin
			if (rx_frame.sub == sub_link_off)
				op_dec = op_link_off;
			else if (rx_frame.sub == sub_link_on)
				op_dec = op_link_on;
		end
		else if (rx_frame.code == code_dds)
		begin
			case (rx_frame.sub)
				sub_wave: op_dec = op_wave;
				sub_duty: op_dec = op_duty;
				sub_freq: op_dec = op_freq;
				sub_amp:  op_dec = op_amp;
				sub_bias: op_dec = op_bias;
				default:  op_dec = op_none;
			endcase
		end
		else if (rx_frame.code == code_adc)
		begin
			if (rx_frame.sub == sub_rd_start)
				op_dec = op_read_start;
			else if (rx_frame.sub == sub_rd_stop)
				op_dec = op_read_stop;
		end
	end

	always_ff @(posedge clk_50m)
	begin
		if (!rst)
		begin
			cmd_valid <= 1'b0;
			cmd_op    <= op_none;
		end
		else
		begin
			cmd_valid <= rx_ready && chk_ok;   // bad frames vanish here
			if (rx_ready && chk_ok)
				cmd_op <= op_dec;
		end
	end

	// sub, arg_hi, arg_lo
	always_ff @(posedge clk_50m)
	begin
		if (rx_ready && chk_ok)
			cmd_arg <= {rx_frame.sub, rx_frame.arg_hi, rx_frame.arg_lo};
	end

endmodule

//--- hdl/dds_config_regs.sv
`timescale 1ns/1ps

module dds_config_regs import ecs_pkg::*; (
	input  logic        clk_50m,
	input  logic        rst,
	input  logic        cmd_valid,
	input  cmd_op_t     cmd_op,
	input  logic [23:0] cmd_arg,
	output dio_t        dio,
	output dds_cfg_t    dds_cfg
);

	logic [7:0] arg_sub;
	logic [7:0] arg_hi;
	logic [7:0] arg_lo;

	assign arg_sub = cmd_arg[23:16];
	assign arg_hi  = cmd_arg[15:8];
	assign arg_lo  = cmd_arg[7:0];

	// one field per opcode, rest hold
	always_ff @(posedge clk_50m)
	begin
		if (!rst)
		begin
			dio     <= dio_rst;
			dds_cfg <= dds_cfg_rst;
		end
		else if (cmd_valid)
		begin
			case (cmd_op)
				op_dio:
				begin
					dio.dio1 <= arg_sub;
					dio.dio2 <= arg_hi;
					dio.dio3 <= arg_lo;
				end
				op_wave: dds_cfg.wave      <= wave_t'(arg_hi[2:0]);   // 5..7 passed as is
				op_duty: dds_cfg.duty      <= {arg_hi[5:0], arg_lo};
				op_freq: dds_cfg.freq_incr <= {arg_hi[3:0], arg_lo};
				op_amp:  dds_cfg.amp       <= {arg_hi, arg_lo};
				op_bias: dds_cfg.bias      <= {arg_hi, arg_lo};
				default: ;   // link and read ops handled elsewhere
			endcase
		end
	end

endmodule

//--- hdl/ecs_pkg.sv
package ecs_pkg;

	// length always comes from arg_hi/arg_lo
	parameter int len_w = 16;

	// received command, code byte first
	typedef struct packed {
		logic [7:0] code;
		logic [7:0] sub;
		logic [7:0] arg_hi;
		logic [7:0] arg_lo;
		logic [7:0] check;   // xor of the four bytes above
	} cmd_frame_t;

	// reply to host, b1 goes out first
	typedef struct packed {
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		logic [7:0] b4;
	} tx_frame_t;

	typedef enum logic [2:0] {
		wave_dc     = 3'd0,
		wave_sine   = 3'd1,
		wave_saw    = 3'd2,
		wave_tri    = 3'd3,
		wave_square = 3'd4
	} wave_t;

	typedef struct packed {
		wave_t       wave;
		logic [13:0] duty;
		logic [11:0] freq_incr;   // phase step per dds clock
		logic [15:0] amp;
		logic [15:0] bias;        // offset binary, 8000 is mid scale
	} dds_cfg_t;

	typedef struct packed {
		logic [7:0] dio1;
		logic [7:0] dio2;
		logic [7:0] dio3;
	} dio_t;

	typedef enum logic [3:0] {
		op_none,
		op_dio,
		op_link_off,
		op_link_on,
		op_wave,
		op_duty,
		op_freq,
		op_amp,
		op_bias,
		op_read_start,
		op_read_stop
	} cmd_op_t;

	typedef enum logic [1:0] {
		st_beacon,
		st_idle,
		st_muted,
		st_read
	} reply_state_t;

	// code bytes
	localparam logic [7:0] code_link   = 8'h02;
	localparam logic [7:0] code_dds    = 8'h03;
	localparam logic [7:0] code_adc    = 8'h04;
	localparam logic [3:0] code_dio    = 4'h1;   // high nibble only
	localparam logic [7:0] code_sample = 8'h20;
	localparam logic [7:0] code_beacon = 8'h55;

	// sub bytes, meaning depends on code
	localparam logic [7:0] sub_link_off = 8'h01;
	localparam logic [7:0] sub_link_on  = 8'h02;
	localparam logic [7:0] sub_wave     = 8'h01;
	localparam logic [7:0] sub_freq     = 8'h02;
	localparam logic [7:0] sub_amp      = 8'h03;
	localparam logic [7:0] sub_bias     = 8'h04;
	localparam logic [7:0] sub_duty     = 8'h08;
	localparam logic [7:0] sub_rd_start = 8'h03;
	localparam logic [7:0] sub_rd_stop  = 8'h04;

	// power-up outputs
	localparam dio_t dio_rst = '{dio1: 8'hFF, dio2: 8'h00, dio3: 8'h00};
	localparam dds_cfg_t dds_cfg_rst = '{
		wave:      wave_sine,
		duty:      14'h2000,
		freq_incr: 12'h001,
		amp:       16'hFFFF,
		bias:      16'h8000
	};

endpackage

//--- hdl/reply_framer.sv
`timescale 1ns/1ps

module reply_framer import ecs_pkg::*; #(
	parameter int addr_w   = 8,
	parameter int sample_w = 14
) (
	input  logic                clk_50m,
	input  logic                rst,
	input  logic [1:0]          frame_sel,
	input  logic [addr_w-1:0]   adc_rd_addr,
	input  logic [sample_w-1:0] adc_sample,
	output tx_frame_t           tx_frame
);

	logic [15:0] samp_ext;   // zero padded to two bytes

	assign samp_ext = 16'(adc_sample);

	always_ff @(posedge clk_50m)
	begin
		if (!rst)
			tx_frame <= tx_frame_t'({4{code_beacon}});
		else if (frame_sel[1])
		begin
			tx_frame.b1 <= code_sample;
			tx_frame.b2 <= 8'(adc_rd_addr);   // low address byte
			tx_frame.b3 <= samp_ext[15:8];
			tx_frame.b4 <= samp_ext[7:0];
		end
		else if (frame_sel[0])
			tx_frame <= tx_frame_t'({4{code_beacon}});
		// otherwise hold, host may still be sending it
	end

endmodule

//--- hdl/reply_fsm.sv
`timescale 1ns/1ps

module reply_fsm import ecs_pkg::*; (
	input  logic         clk_50m,
	input  logic         rst,
	input  logic         cmd_valid,
	input  cmd_op_t      cmd_op,
	input  logic         len_zero,
	input  logic         tx_done,
	input  logic         last,
	output logic         cnt_load,
	output logic         cnt_step,
	output logic [1:0]   frame_sel,   // [1] load sample, [0] load beacon
	output logic         tx_en,
	output reply_state_t state
);

	reply_state_t state_nxt;
	logic [1:0]   fetch_wait;   // ram address to sample delay
	logic         frame_out;    // host took the current frame

	assign frame_out = tx_done && tx_en && (state == st_read);

	// entry to st_read, also restarts a running read
	assign cnt_load = cmd_valid && (cmd_op == op_read_start) && !len_zero
		&& (state != st_muted);
	assign cnt_step = frame_out && !cnt_load;

	assign frame_sel[0] = (state == st_beacon);
	assign frame_sel[1] = fetch_wait[1] && (state == st_read);   // sample valid now

	always_comb
	begin
		state_nxt = state;
		case (state)
			st_muted:
				if (cmd_valid && cmd_op == op_link_on)
					state_nxt = st_idle;
			default:
			begin
				if (frame_out && last)
					state_nxt = st_idle;   // final frame gone
				if (cmd_valid && state == st_beacon)
					state_nxt = st_idle;   // any good frame ends the beacon
				if (cmd_valid)
				begin
					case (cmd_op)
						op_link_off:   state_nxt = st_muted;
						op_read_start: state_nxt = len_zero ? st_idle : st_read;
						op_read_stop:  state_nxt = st_idle;
						default: ;
					endcase
				end
			end
		endcase
	end

	always_ff @(posedge clk_50m)
	begin
		if (!rst)
		begin
			state      <= st_beacon;
			tx_en      <= 1'b1;
			fetch_wait <= 2'b00;
		end
		else
		begin
			state      <= state_nxt;
			fetch_wait <= {fetch_wait[0], cnt_load || cnt_step};
			if (state_nxt != st_read)
				tx_en <= (state_nxt == st_beacon);   // only beacon sends unasked
			else if (cnt_load || cnt_step)
				tx_en <= 1'b0;   // wait for the next sample
			else if (frame_sel[1])
				tx_en <= 1'b1;
		end
	end

endmodule

//--- hdl/sample_read_counter.sv
`timescale 1ns/1ps

module sample_read_counter import ecs_pkg::*; #(
	parameter int addr_w = 8
) (
	input  logic              clk_50m,
	input  logic              rst,
	input  logic              cnt_load,
	input  logic              cnt_step,
	input  logic [len_w-1:0]  len,
	output logic [addr_w-1:0] adc_rd_addr,
	output logic              last
);

	logic [len_w-1:0] idx;        // samples sent so far
	logic [len_w-1:0] idx_last;   // length minus 1

	always_ff @(posedge clk_50m)
	begin
		if (!rst)
		begin
			idx      <= '0;
			idx_last <= '0;
		end
		else if (cnt_load)
		begin
			idx      <= '0;
			idx_last <= len - 1'b1;   // len nonzero here
		end
		else if (cnt_step)
			idx <= idx + 1'b1;
	end

	// ram address wraps, full index does not
	assign adc_rd_addr = idx[addr_w-1:0];
	assign last        = (idx == idx_last);

endmodule

//--- hdl/uart_cmd_ctrl.sv
`timescale 1ns/1ps

module uart_cmd_ctrl import ecs_pkg::*; #(
	parameter int addr_w   = 8,
	parameter int sample_w = 14   // at most 16
) (
	input  logic                clk_50m,
	input  logic                rst,
	input  cmd_frame_t          rx_frame,
	input  logic                rx_ready,
	input  logic [sample_w-1:0] adc_sample,
	input  logic                tx_done,
	output dio_t                dio,
	output dds_cfg_t            dds_cfg,
	output logic [addr_w-1:0]   adc_rd_addr,
	output tx_frame_t           tx_frame,
	output logic                tx_en
);

	logic         cmd_valid;
	cmd_op_t      cmd_op;
	logic [23:0]  cmd_arg;    // sub, arg_hi, arg_lo
	logic         len_zero;
	logic         cnt_load;
	logic         cnt_step;
	logic         last;
	logic [1:0]   frame_sel;
	reply_state_t fsm_state;  // observed by the checkers

	assign len_zero = (cmd_arg[15:0] == '0);

	cmd_decoder cmd_decoder_inst (
		.clk_50m   (clk_50m),
		.rst       (rst),
		.rx_frame  (rx_frame),
		.rx_ready  (rx_ready),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_arg   (cmd_arg)
	);

	dds_config_regs dds_config_regs_inst (
		.clk_50m   (clk_50m),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_arg   (cmd_arg),
		.dio       (dio),
		.dds_cfg   (dds_cfg)
	);

	sample_read_counter #(
		.addr_w (addr_w)
	) sample_read_counter_inst (
		.clk_50m     (clk_50m),
		.rst         (rst),
		.cnt_load    (cnt_load),
		.cnt_step    (cnt_step),
		.len         (cmd_arg[15:0]),
		.adc_rd_addr (adc_rd_addr),
		.last        (last)
	);

	reply_fsm reply_fsm_inst (
		.clk_50m   (clk_50m),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.len_zero  (len_zero),
		.tx_done   (tx_done),
		.last      (last),
		.cnt_load  (cnt_load),
		.cnt_step  (cnt_step),
		.frame_sel (frame_sel),
		.tx_en     (tx_en),
		.state     (fsm_state)
	);

	reply_framer #(
		.addr_w   (addr_w),
		.sample_w (sample_w)
	) reply_framer_inst (
		.clk_50m     (clk_50m),
		.rst         (rst),
		.frame_sel   (frame_sel),
		.adc_rd_addr (adc_rd_addr),
		.adc_sample  (adc_sample),
		.tx_frame    (tx_frame)
	);

endmodule

//--- testbench/uart_cmd_ctrl_asserts.sv
`timescale 1ns/1ps

module uart_cmd_ctrl_asserts import ecs_pkg::*; (
	input logic         clk_50m,
	input logic         rst,
	input reply_state_t state,
	input logic         tx_en,
	input logic         tx_done,
	input tx_frame_t    tx_frame,
	input logic         cnt_load,
	input logic         cnt_step
);

	int fail_cnt = 0;   // failed properties so far, watched by the testbench

	// nothing goes out unasked outside beacon and read
	quiet_states: assert property (@(posedge clk_50m) disable iff (!rst)
		(state == st_idle || state == st_muted) |-> !tx_en)
		else
		begin
			fail_cnt = fail_cnt + 1;
			$error("tx_en high in idle or muted state");
		end

	// frame under transmission must not move
	frame_held: assert property (@(posedge clk_50m) disable iff (!rst)
		(tx_en && !tx_done) |=> $stable(tx_frame))
		else
		begin
			fail_cnt = fail_cnt + 1;
			$error("tx_frame changed while the transmitter owned it");
		end

	load_step_excl: assert property (@(posedge clk_50m) disable iff (!rst)
		!(cnt_load && cnt_step))
		else
		begin
			fail_cnt = fail_cnt + 1;
			$error("cnt_load and cnt_step high together");
		end

endmodule

bind uart_cmd_ctrl uart_cmd_ctrl_asserts uart_cmd_ctrl_asserts_inst (
	.clk_50m  (clk_50m),
	.rst      (rst),
	.state    (fsm_state),
	.tx_en    (tx_en),
	.tx_done  (tx_done),
	.tx_frame (tx_frame),
	.cnt_load (cnt_load),
	.cnt_step (cnt_step)
);

//--- testbench/uart_cmd_ctrl_tb.sv
`timescale 1ns/1ps

module uart_cmd_ctrl_tb import ecs_pkg::*; ();

	localparam int addr_w   = 8;
	localparam int sample_w = 14;
	localparam string trace_path = "testbench/uart_cmd_ctrl_trace.txt";

	logic                clk_50m = 1'b0;
	logic                rst;
	cmd_frame_t          rx_frame;
	logic                rx_ready;
	logic [sample_w-1:0] adc_sample = '0;
	logic                tx_done;
	dio_t                dio;
	dds_cfg_t            dds_cfg;
	logic [addr_w-1:0]   adc_rd_addr;
	tx_frame_t           tx_frame;
	logic                tx_en;

	logic [sample_w-1:0] ram [0:(1<<addr_w)-1];   // external sample ram
	int cycles = 0;
	int limit  = 0;   // 0 until the trace is scanned
	int rd_idx = 0;   // next expected read address

	uart_cmd_ctrl #(
		.addr_w   (addr_w),
		.sample_w (sample_w)
	) uart_cmd_ctrl_inst (
		.clk_50m     (clk_50m),
		.rst         (rst),
		.rx_frame    (rx_frame),
		.rx_ready    (rx_ready),
		.adc_sample  (adc_sample),
		.tx_done     (tx_done),
		.dio         (dio),
		.dds_cfg     (dds_cfg),
		.adc_rd_addr (adc_rd_addr),
		.tx_frame    (tx_frame),
		.tx_en       (tx_en)
	);

	always #10 clk_50m = ~clk_50m;   // 50 MHz

	always @(posedge clk_50m)
		adc_sample <= ram[adc_rd_addr];   // one cycle read latency

	always @(posedge clk_50m)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("run did not finish within %0d cycles", limit);
			$display("sim failed");
			$fatal(1, "timeout");
		end
		if (uart_cmd_ctrl_inst.uart_cmd_ctrl_asserts_inst.fail_cnt != 0)
		begin
			$display("a reply path assertion failed");
			$display("sim failed");
			$fatal(1, "assertion");
		end
	end

	task automatic check_dio(input string name, input dio_t exp, input dio_t act);
		if (exp !== act)
		begin
			$display("FAILED %s dio expected %h actual %h", name, exp, act);
			$display("sim failed");
			$fatal(1, "dio mismatch");
		end
	endtask

	task automatic check_cfg(input string name, input dds_cfg_t exp, input dds_cfg_t act);
		if (exp !== act)
		begin
			$display("FAILED %s dds_cfg expected %h actual %h", name, exp, act);
			$display("sim failed");
			$fatal(1, "dds_cfg mismatch");
		end
	endtask

	task automatic check_tx(input string name, input tx_frame_t exp, input tx_frame_t act);
		if (exp !== act)
		begin
			$display("FAILED %s tx_frame expected %h actual %h", name, exp, act);
			$display("sim failed");
			$fatal(1, "tx_frame mismatch");
		end
	endtask

	task automatic check_addr(input string name, input logic [addr_w-1:0] exp,
		input logic [addr_w-1:0] act);
		if (exp !== act)
		begin
			$display("FAILED %s adc_rd_addr expected %h actual %h", name, exp, act);
			$display("sim failed");
			$fatal(1, "adc_rd_addr mismatch");
		end
	endtask

	task automatic check_en(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("FAILED %s tx_en expected %b actual %b", name, exp, act);
			$display("sim failed");
			$fatal(1, "tx_en mismatch");
		end
	endtask

	// one rx_ready pulse, then let the 2-cycle update settle
	task automatic send_cmd(input cmd_frame_t f);
		@(posedge clk_50m);
		rx_frame <= f;
		rx_ready <= 1'b1;
		@(posedge clk_50m);
		rx_ready <= 1'b0;
		repeat (3) @(posedge clk_50m);
	endtask

	// expected reply for a sample address
	function automatic tx_frame_t sample_frame(input int idx);
		logic [15:0] s16;
		tx_frame_t   fr;
		s16   = 16'(ram[idx % (1 << addr_w)]);
		fr.b1 = code_sample;
		fr.b2 = 8'(idx);
		fr.b3 = s16[15:8];
		fr.b4 = s16[7:0];
		return fr;
	endfunction

	// accept count frames, holding off tx_done on the first for hold cycles
	task automatic take_frames(input string name, input int count, input int hold);
		tx_frame_t exp;
		int        dly;
		for (int i = 0; i < count; i++)
		begin
			@(negedge clk_50m);
			while (!tx_en)
				@(negedge clk_50m);
			exp = sample_frame(rd_idx);
			check_tx(name, exp, tx_frame);
			check_addr(name, addr_w'(rd_idx), adc_rd_addr);   // ram address wraps
			if (i == 0)
			begin
				repeat (hold)
				begin
					@(negedge clk_50m);
					check_en(name, 1'b1, tx_en);
					check_tx(name, exp, tx_frame);
				end
			end
			dly = $urandom % 8;   // host side latency
			repeat (dly) @(posedge clk_50m);
			@(posedge clk_50m);
			tx_done <= 1'b1;
			@(posedge clk_50m);
			tx_done <= 1'b0;
			rd_idx++;
		end
	endtask

	initial
	begin
		int         fd;
		int         n;
		int         code, sub, hi, lo, chk;
		int         cnt, hold, en;
		int         addr, val;
		int         dio_v, wv, duty, fr, amp, bias;
		int         cmds;
		int         frames;
		string      kind, name, rest;
		cmd_frame_t f;
		dds_cfg_t   ec;

		cmds   = 0;
		frames = 0;
		n = $urandom(32'h9bd2_522f);
		rst      = 1'b0;
		rx_frame = '0;
		rx_ready = 1'b0;
		tx_done  = 1'b0;
		for (int i = 0; i < (1 << addr_w); i++)
			ram[i] = sample_w'((i * 173) ^ (i << 6) ^ 14'h1a5);   // whole-address fill

		// first pass sizes the timeout
		fd = $fopen(trace_path, "r");
		if (fd == 0)
		begin
			$display("cannot open trace file %s", trace_path);
			$display("sim failed");
			$fatal(1, "no trace");
		end
		while ($fscanf(fd, "%s", kind) == 1)
		begin
			if (kind == "CMD")
				cmds++;
			else if (kind == "RD")
			begin
				n = $fscanf(fd, "%s %d", name, cnt);
				frames += cnt;
			end
			n = $fgets(rest, fd);
		end
		$fclose(fd);
		limit = 4000 + 64 * (cmds + frames);

		repeat (5) @(posedge clk_50m);
		rst <= 1'b1;

		fd = $fopen(trace_path, "r");
		while ($fscanf(fd, "%s", kind) == 1)
		begin
			if (kind == "RAM")
			begin
				n = $fscanf(fd, "%h %h", addr, val);
				ram[addr] = sample_w'(val);
			end
			else if (kind == "CMD")
			begin
				n = $fscanf(fd, "%s %h %h %h %h %h", name, code, sub, hi, lo, chk);
				f = '{code: code[7:0], sub: sub[7:0], arg_hi: hi[7:0],
					arg_lo: lo[7:0], check: chk[7:0]};
				if (code == 4 && sub == 3)
					rd_idx = 0;   // a read always starts at address 0
				send_cmd(f);
			end
			else if (kind == "CFG")
			begin
				n = $fscanf(fd, "%s %h %h %h %h %h %h", name, dio_v, wv, duty, fr, amp, bias);
				@(negedge clk_50m);
				check_dio(name, dio_t'(24'(dio_v)), dio);
				ec.wave      = wave_t'(wv[2:0]);
				ec.duty      = duty[13:0];
				ec.freq_incr = fr[11:0];
				ec.amp       = amp[15:0];
				ec.bias      = bias[15:0];
				check_cfg(name, ec, dds_cfg);
			end
			else if (kind == "RD")
			begin
				n = $fscanf(fd, "%s %d %d %d", name, cnt, hold, en);
				take_frames(name, cnt, hold);
				if (en == 0)
				begin
					repeat (4) @(negedge clk_50m);
					check_en(name, 1'b0, tx_en);
				end
				else if (cnt == 0)
				begin
					@(negedge clk_50m);
					check_en(name, 1'b1, tx_en);
					check_tx(name, tx_frame_t'({4{code_beacon}}), tx_frame);
				end
			end
			n = $fgets(rest, fd);   // rest of line, or a comment
		end
		$fclose(fd);

		if (uart_cmd_ctrl_inst.uart_cmd_ctrl_asserts_inst.fail_cnt == 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			$display("a reply path assertion failed");
			$display("sim failed");
			$fatal(1, "assertion");
		end
	end

endmodule

//--- testbench/uart_cmd_ctrl_trace.txt
# RAM addr sample | CMD name code sub arg_hi arg_lo check | CFG name dio wave duty freq amp bias
# RD name frames hold_cycles en_after (en_after 1 with 0 frames checks the beacon)
RAM 00 3fff
RAM 01 1234
RAM 02 0abc
RD beacon 0 0 1
CMD bad_dio 12 34 56 78 00
CFG after_bad ff0000 1 2000 001 ffff 8000
RD still_beacon 0 0 1
CMD dio 12 a5 3c 0f 84
CFG dio a53c0f 1 2000 001 ffff 8000
RD beacon_off 0 0 0
CMD wave 03 01 03 00 01
CMD duty 03 08 15 67 79
CMD freq 03 02 f4 56 a3
CMD amp 03 03 12 34 26
CMD bias 03 04 7f 00 78
CFG dds_all a53c0f 3 1567 456 1234 7f00
CMD bad_amp 03 03 00 00 ff
CFG bad_amp a53c0f 3 1567 456 1234 7f00
CMD read4 04 03 00 04 03
RD read4 4 6 0
CMD read5 04 03 00 05 02
RD read5_part 2 0 1
CMD read_stop 04 04 00 00 00
RD stopped 0 0 0
CMD link_off 02 01 00 00 03
RD muted 0 0 0
CMD read_muted 04 03 00 03 04
RD muted_read 0 0 0
CMD link_on 02 02 00 00 00
CMD read3 04 03 00 03 04
RD read3 3 0 0
CMD read_zero 04 03 00 00 07
RD read_zero 0 0 0

//--- verilog.f
hdl/ecs_pkg.sv
hdl/cmd_decoder.sv
hdl/dds_config_regs.sv
hdl/sample_read_counter.sv
hdl/reply_fsm.sv
hdl/reply_framer.sv
hdl/uart_cmd_ctrl.sv
testbench/uart_cmd_ctrl_asserts.sv
testbench/uart_cmd_ctrl_tb.sv
